// File: Makefile
TOP = lsu_region_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: logic/data_ram.sv
module data_ram (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t req_i,
  output lsu_pkg::lsu_rsp_t rsp_o
);

  lsu_pkg::data_t      mem [lsu_pkg::RAM_WORDS];
  lsu_pkg::ram_index_t idx;
  logic                rsp_valid_q;
  lsu_pkg::data_t      rsp_data_q;

  assign idx = req_i.addr[lsu_pkg::RAM_IDX_HI:lsu_pkg::RAM_IDX_LO];

  // byte-enable write, read returns the word before any update
  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rsp_data_q <= '0;
      end else begin
        rsp_data_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rsp_data_q;

endmodule

// File: logic/lsu_dispatch.sv
module lsu_dispatch (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              ext_credit_i,
  output lsu_pkg::lsu_req_t ram_req_o,
  output lsu_pkg::lsu_req_t ext_req_o,
  output logic              tag_push_o,
  output lsu_pkg::route_t   tag_o
);

  lsu_pkg::lsu_req_t  head;
  logic               buf_empty;
  logic               buf_full;
  lsu_pkg::route_t    is_ext;
  logic               dispatch;
  logic               ext_send;
  lsu_pkg::cred_cnt_t ext_cnt_q;

  // input buffer, sized by the requester credits
  sync_fifo #(
    .WIDTH ($bits(lsu_pkg::lsu_req_t)),
    .DEPTH (lsu_pkg::REQ_CREDITS)
  ) req_buf_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (req_i.valid),
    .push_data_i (req_i),
    .pop_i       (dispatch),
    .head_o      (head),
    .empty_o     (buf_empty),
    .full_o      (buf_full)
  );

  // anything outside the local region goes external
  assign is_ext = (head.addr[lsu_pkg::REGION_HI:lsu_pkg::REGION_LO] != lsu_pkg::LOCAL_REGION);

  // an external head stalls the whole buffer until a slot frees up
  assign dispatch = !buf_empty && (!is_ext || (ext_cnt_q != '0));
  assign ext_send = dispatch && is_ext;

  always_comb begin
    ram_req_o       = head;
    ram_req_o.valid = dispatch && !is_ext;
    ext_req_o       = head;
    ext_req_o.valid = ext_send;
  end

  assign tag_push_o = dispatch;
  assign tag_o      = is_ext;

  // external credits, one spent per send, one back per pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_cnt_q <= lsu_pkg::EXT_CREDITS;
    end else begin
      ext_cnt_q <= ext_cnt_q + lsu_pkg::cred_cnt_t'(ext_credit_i)
                   - lsu_pkg::cred_cnt_t'(ext_send);
    end
  end

  // requester sent without holding a credit
  assert property (@(posedge clk) disable iff (!rst_n) req_i.valid |-> !buf_full)
    else $error("request arrived while input buffer full");

  // device returned more credits than it was given
  assert property (@(posedge clk) disable iff (!rst_n) ext_cnt_q <= lsu_pkg::EXT_CREDITS)
    else $error("external credit count above limit");

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

  // basic word and address types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  ram_index_t;

  // credit counter, wide enough for both credit pools
  typedef logic [2:0] cred_cnt_t;

  // 1 means the access went out on the external port
  typedef logic route_t;

  // region field of the address that picks the local RAM
  localparam int          REGION_HI    = 31;
  localparam int          REGION_LO    = 20;
  localparam logic [11:0] LOCAL_REGION = 12'h001;

  // data RAM geometry, word addressed
  localparam int RAM_WORDS  = 256;
  localparam int RAM_IDX_HI = 9;
  localparam int RAM_IDX_LO = 2;

  // requester credits, also the depth of every internal FIFO
  localparam int REQ_CREDITS = 4;

  // external slots after reset
  localparam cred_cnt_t EXT_CREDITS = 3'd2;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } lsu_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
  } lsu_rsp_t;

endpackage

// File: logic/lsu_region.sv
module lsu_region (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              req_credit_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output lsu_pkg::lsu_req_t ext_req_o,
  input  logic              ext_credit_i,
  input  lsu_pkg::lsu_rsp_t ext_rsp_i
);

  lsu_pkg::lsu_req_t ram_req;
  lsu_pkg::lsu_rsp_t ram_rsp;
  logic              tag_push;
  lsu_pkg::route_t   tag;

  // buffer and address decode
  lsu_dispatch lsu_dispatch_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .ext_credit_i (ext_credit_i),
    .ram_req_o    (ram_req),
    .ext_req_o    (ext_req_o),
    .tag_push_o   (tag_push),
    .tag_o        (tag)
  );

  // local region storage
  data_ram data_ram_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  // back into request order
  rsp_merge rsp_merge_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .tag_push_i   (tag_push),
    .tag_i        (tag),
    .ram_rsp_i    (ram_rsp),
    .ext_rsp_i    (ext_rsp_i),
    .rsp_o        (rsp_o),
    .req_credit_o (req_credit_o)
  );

endmodule

// File: logic/rsp_merge.sv
module rsp_merge (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tag_push_i,
  input  lsu_pkg::route_t   tag_i,
  input  lsu_pkg::lsu_rsp_t ram_rsp_i,
  input  lsu_pkg::lsu_rsp_t ext_rsp_i,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output logic              req_credit_o
);

  lsu_pkg::route_t    tag_head;
  logic               tag_empty;
  logic               tag_full;
  lsu_pkg::data_t     loc_head;
  lsu_pkg::data_t     ext_head;
  logic               loc_empty;
  logic               ext_empty;
  logic               loc_full;
  logic               ext_full;
  logic               loc_avail;
  logic               ext_avail;
  logic               take;
  logic               loc_take;
  logic               ext_take;
  logic               loc_push;
  logic               ext_push;
  lsu_pkg::data_t     sel_data;
  logic               rsp_valid_q;
  lsu_pkg::data_t     rsp_data_q;
  lsu_pkg::cred_cnt_t ext_wait_q;

  // route of every access in flight, oldest at the head
  sync_fifo #(
    .WIDTH (1),
    .DEPTH (lsu_pkg::REQ_CREDITS)
  ) tag_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (tag_push_i),
    .push_data_i (tag_i),
    .pop_i       (take),
    .head_o      (tag_head),
    .empty_o     (tag_empty),
    .full_o      (tag_full)
  );

  sync_fifo #(
    .WIDTH ($bits(lsu_pkg::data_t)),
    .DEPTH (lsu_pkg::REQ_CREDITS)
  ) loc_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (loc_push),
    .push_data_i (ram_rsp_i.rdata),
    .pop_i       (loc_take && !loc_empty),
    .head_o      (loc_head),
    .empty_o     (loc_empty),
    .full_o      (loc_full)
  );

  sync_fifo #(
    .WIDTH ($bits(lsu_pkg::data_t)),
    .DEPTH (lsu_pkg::REQ_CREDITS)
  ) ext_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (ext_push),
    .push_data_i (ext_rsp_i.rdata),
    .pop_i       (ext_take && !ext_empty),
    .head_o      (ext_head),
    .empty_o     (ext_empty),
    .full_o      (ext_full)
  );

  // an empty FIFO is bypassed by the response arriving this cycle
  always_comb begin
    loc_avail = !loc_empty || ram_rsp_i.valid;
    ext_avail = !ext_empty || ext_rsp_i.valid;
    take      = !tag_empty && (tag_head ? ext_avail : loc_avail);
    loc_take  = take && !tag_head;
    ext_take  = take && tag_head;
    loc_push  = ram_rsp_i.valid && !(loc_take && loc_empty);
    ext_push  = ext_rsp_i.valid && !(ext_take && ext_empty);
    if (tag_head) begin
      sel_data = ext_empty ? ext_rsp_i.rdata : ext_head;
    end else begin
      sel_data = loc_empty ? ram_rsp_i.rdata : loc_head;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp_data_q <= sel_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      ext_wait_q  <= '0;
    end else begin
      rsp_valid_q <= take;
      ext_wait_q  <= ext_wait_q + lsu_pkg::cred_cnt_t'(tag_push_i && tag_i)
                     - lsu_pkg::cred_cnt_t'(ext_rsp_i.valid);
    end
  end

  assign rsp_o.valid  = rsp_valid_q;
  assign rsp_o.rdata  = rsp_data_q;
  // credit goes back together with its response
  assign req_credit_o = rsp_valid_q;

  // device answered something that was never sent to it
  assert property (@(posedge clk) disable iff (!rst_n)
    ext_rsp_i.valid |-> (ext_wait_q != '0) || (tag_push_i && tag_i))
    else $error("external response with no external request outstanding");

  // tags and responses are bounded by the requester credits
  assert property (@(posedge clk) disable iff (!rst_n)
    !(tag_full && tag_push_i) && !(loc_full && loc_push) && !(ext_full && ext_push))
    else $error("response path overflow");

endmodule

// File: logic/sync_fifo.sv
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] head_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign head_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // storage only, no reset needed
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  // callers must respect full and empty
  assert property (@(posedge clk) disable iff (!rst_n) !(push_i && full_o) && !(pop_i && empty_o))
    else $error("sync_fifo overflow or underflow");

endmodule

// File: sources.f
logic/lsu_pkg.sv
logic/sync_fifo.sv
logic/lsu_dispatch.sv
logic/data_ram.sv
logic/rsp_merge.sv
logic/lsu_region.sv
test/tb_clock.sv
test/lsu_region_tb.sv

// File: test/lsu_region_tb.sv
module lsu_region_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;

  logic              clk;
  logic              rst_n;
  lsu_pkg::lsu_req_t req;
  logic              req_credit;
  lsu_pkg::lsu_rsp_t rsp;
  lsu_pkg::lsu_req_t ext_req;
  logic              ext_credit;
  lsu_pkg::lsu_rsp_t ext_rsp;

  // trace contents
  string             trace_name [$];
  lsu_pkg::lsu_req_t trace_req [$];
  lsu_pkg::data_t    trace_exp [$];

  // responses the requester still waits for, oldest first
  string             exp_name [$];
  lsu_pkg::data_t    exp_data [$];
  int                credits;

  // external device state
  lsu_pkg::data_t    ext_mem [logic [29:0]];
  lsu_pkg::lsu_req_t pend_req [$];
  int                pend_due [$];
  int                ext_unanswered;
  int                ext_seen;
  int                cycle;

  tb_clock tb_clock_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lsu_region lsu_region_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .req_credit_o (req_credit),
    .rsp_o        (rsp),
    .ext_req_o    (ext_req),
    .ext_credit_i (ext_credit),
    .ext_rsp_i    (ext_rsp)
  );

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic expect_equal(string name, lsu_pkg::data_t expected, lsu_pkg::data_t actual);
    if (expected !== actual) begin
      $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      abort_run("a checked value differs from its expected value");
    end
  endtask

  function automatic lsu_pkg::data_t merge_bytes(lsu_pkg::data_t old_word,
                                                 lsu_pkg::data_t new_word,
                                                 lsu_pkg::be_t   be);
    lsu_pkg::data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic is_local(lsu_pkg::addr_t addr);
    return addr[lsu_pkg::REGION_HI:lsu_pkg::REGION_LO] == lsu_pkg::LOCAL_REGION;
  endfunction

  task automatic load_trace();
    int             fd;
    string          line;
    string          name;
    logic [31:0]    addr;
    logic [31:0]    we;
    logic [31:0]    be;
    logic [31:0]    wdata;
    logic [31:0]    expected;
    lsu_pkg::lsu_req_t entry;
    fd = $fopen("test/lsu_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file test/lsu_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%s %h %h %h %h %h", name, addr, we, be, wdata, expected) == 6) begin
          entry.valid = 1'b1;
          entry.addr  = addr;
          entry.we    = we[0];
          entry.be    = be[3:0];
          entry.wdata = wdata;
          trace_name.push_back(name);
          trace_req.push_back(entry);
          trace_exp.push_back(expected);
        end
      end
    end
    $fclose(fd);
    if (trace_req.size() == 0) begin
      abort_run("the trace file holds no accesses");
    end
  endtask

  // requester side, sampled before the edge updates it
  always @(posedge clk) begin
    if (rst_n) begin
      expect_equal("credit_with_rsp", 32'(rsp.valid), 32'(req_credit));
      if (req_credit) begin
        credits++;
        if (credits > lsu_pkg::REQ_CREDITS) begin
          abort_run("more request credits came back than were spent");
        end
      end
      if (rsp.valid) begin
        if (exp_name.size() == 0) begin
          abort_run("a response arrived with no request outstanding");
        end
        expect_equal(exp_name.pop_front(), exp_data.pop_front(), rsp.rdata);
      end
    end
  end

  // external device, takes requests at the edge the DUT sends them
  initial begin
    void'($urandom(32'h289a));
    forever begin
      @(posedge clk);
      cycle++;
      if (rst_n && ext_req.valid) begin
        if (ext_unanswered >= int'(lsu_pkg::EXT_CREDITS)) begin
          abort_run("the external port sent a request without a free slot");
        end
        if (is_local(ext_req.addr)) begin
          abort_run("a local address appeared on the external port");
        end
        pend_req.push_back(ext_req);
        pend_due.push_back(cycle + int'($urandom % 6));
        ext_unanswered++;
        ext_seen++;
      end
    end
  end

  // answers in order, one per cycle, slot freed with the answer
  always @(negedge clk) begin
    lsu_pkg::lsu_req_t r;
    logic [29:0]       word;
    ext_rsp    = '0;
    ext_credit = 1'b0;
    if (pend_req.size() > 0 && cycle >= pend_due[0]) begin
      r    = pend_req.pop_front();
      void'(pend_due.pop_front());
      word = r.addr[31:2];
      ext_rsp.valid = 1'b1;
      if (r.we) begin
        ext_mem[word] = merge_bytes(ext_mem.exists(word) ? ext_mem[word] : '0, r.wdata, r.be);
        ext_rsp.rdata = '0;
      end else begin
        ext_rsp.rdata = ext_mem.exists(word) ? ext_mem[word] : '0;
      end
      ext_credit = 1'b1;
      ext_unanswered--;
    end
  end

  initial begin
    int waited;
    int expected_ext;
    req            = '0;
    ext_credit     = 1'b0;
    ext_rsp        = '0;
    credits        = lsu_pkg::REQ_CREDITS;
    ext_unanswered = 0;
    ext_seen       = 0;
    cycle          = 0;
    expected_ext   = 0;
    load_trace();

    waited = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout: reset was never released");
      end
    end

    // outputs stay quiet after reset with no traffic
    repeat (3) begin
      @(negedge clk);
      expect_equal("reset_idle", 32'h0, {29'b0, rsp.valid, req_credit, ext_req.valid});
    end

    for (int i = 0; i < trace_req.size(); i++) begin
      waited = 0;
      while (credits == 0) begin
        req = '0;
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run("timeout: no request credit came back");
        end
      end
      req = trace_req[i];
      credits--;
      exp_name.push_back(trace_name[i]);
      exp_data.push_back(trace_exp[i]);
      if (!is_local(trace_req[i].addr)) begin
        expected_ext++;
      end
      @(negedge clk);
    end
    req = '0;

    // drain everything still in flight
    waited = 0;
    while (exp_name.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("timeout: responses still missing after the trace ended");
      end
    end

    expect_equal("final_credits", 32'(lsu_pkg::REQ_CREDITS), 32'(credits));
    expect_equal("ext_request_count", 32'(expected_ext), 32'(ext_seen));
    expect_equal("ext_unanswered", 32'h0, 32'(ext_unanswered));
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: test/lsu_trace.txt
# columns: name addr we be wdata expected_rdata (hex fields after the name)
# we is 1 for a store; stores expect zero rdata
loc_wr0     00100000 1 f 11223344 00000000
loc_rd0     00100000 0 f 00000000 11223344
loc_wr1     00100004 1 f a5a5a5a5 00000000
loc_part1   00100004 1 5 00cc00dd 00000000
loc_rd1     00100004 0 f 00000000 a5cca5dd
loc_part2   00100004 1 a 12345678 00000000
loc_rd2     00100004 0 f 00000000 12cc56dd
alias_rd    00100400 0 f 00000000 11223344
ext_wr0     80000000 1 f deadbeef 00000000
ext_wr1     80000010 1 f cafef00d 00000000
ext_rd0     80000000 0 f 00000000 deadbeef
ext_part    80000010 1 3 0000abcd 00000000
ext_rd1     80000010 0 f 00000000 cafeabcd
ext_wr_hi   00200000 1 f 01020304 00000000
ext_rd_hi   00200000 0 f 00000000 01020304
loc_wr_top  001003fc 1 f 0badc0de 00000000
loc_wr3     00100008 1 f 55aa55aa 00000000
mix_rd0     00100000 0 f 00000000 11223344
mix_rd1     80000000 0 f 00000000 deadbeef
mix_rd2     00100004 0 f 00000000 12cc56dd
mix_rd3     80000010 0 f 00000000 cafeabcd
mix_rd4     001003fc 0 f 00000000 0badc0de
mix_rd5     00200000 0 f 00000000 01020304
mix_rd6     00100008 0 f 00000000 55aa55aa
mix_rd7     80000000 0 f 00000000 deadbeef
mix_rd8     00100000 0 f 00000000 11223344
mix_rd9     80000010 0 f 00000000 cafeabcd
mix_rd10    80000000 0 f 00000000 deadbeef
mix_rd11    00100008 0 f 00000000 55aa55aa
mix_rd12    00200000 0 f 00000000 01020304

// File: test/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset low for three full cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
